/* hdl/alu_pkg.sv */
package alu_pkg;

	// Opcode encoding of the 4-bit instruction field
	// Codes 12 to 15 are control flow, the ALU only passes a through
	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		XOR    = 4'd2,
		RED    = 4'd3,
		SLL    = 4'd4,
		SRA    = 4'd5,
		ROR    = 4'd6,
		PADDSB = 4'd7,
		LW     = 4'd8,
		SW     = 4'd9,
		LLB    = 4'd10,
		LHB    = 4'd11,
		B      = 4'd12,
		BR     = 4'd13,
		PCS    = 4'd14,
		HLT    = 4'd15
	} alu_op_e;

	// Native data word
	typedef logic [15:0] alu_word_t;

	// Condition flags, also used as a per-flag write enable vector
	typedef struct packed {
		// Negative
		logic n;
		// Zero
		logic z;
		// Signed overflow
		logic v;
	} flags_t;

	// One ALU request, 36 bits
	// b is already sign extended by decode
	typedef struct packed {
		alu_op_e   op;
		alu_word_t a;
		alu_word_t b;
	} alu_req_t;

endpackage

/* hdl/add_sub16.sv */
`timescale 1ns/100ps

module add_sub16 import alu_pkg::*; (
	input  alu_word_t a,
	input  alu_word_t b,
	input  logic      sub,
	output alu_word_t sum,
	output logic      ovfl
);

	// Second operand after optional inversion
	alu_word_t b_op;

	// Two's complement of b is ~b plus the carry in
	assign b_op = sub ? ~b : b;

	// Wrapping sum, carry out dropped
	assign sum = a + b_op + {15'd0, sub};

	// Signed overflow
	// Both operands share a sign and the sum sign differs from it
	assign ovfl = (a[15] == b_op[15]) && (sum[15] != a[15]);

endmodule

/* hdl/shift_rotate.sv */
`timescale 1ns/100ps

module shift_rotate import alu_pkg::*; (
	input  alu_word_t  data,
	input  logic [3:0] amount,
	input  alu_op_e    mode,
	output alu_word_t  shifted
);

	// Stage outputs, stage[0] is the raw operand
	alu_word_t stage [0:4];

	// Right shift or rotate, otherwise left shift
	logic go_right;

	assign go_right = (mode == SRA) || (mode == ROR);

	assign stage[0] = data;

	// Log shifter, stage i moves by 2**i when amount[i] is set
	for (genvar i = 0; i < 4; i++) begin : g_stage
		localparam int SHAMT = 1 << i;

		// Bits entering from the top on a right move
		alu_word_t      fill;
		// Fill and operand side by side, shifted right as one
		logic [31:0]    wide;

		always_comb begin
			case (mode)
				// Sign copies in from the top
				SRA:     fill = {16{stage[i][15]}};
				// Bits falling out at the bottom re-enter at the top
				ROR:     fill = stage[i];
				default: fill = '0;
			endcase
		end

		assign wide = {fill, stage[i]} >> SHAMT;

		assign stage[i + 1] = !amount[i] ? stage[i] :
			go_right ? wide[15:0] : (stage[i] << SHAMT);
	end

	assign shifted = stage[4];

endmodule

/* hdl/subword_arith.sv */
`timescale 1ns/100ps

module subword_arith import alu_pkg::*; (
	input  alu_word_t a,
	input  alu_word_t b,
	output alu_word_t paddsb,
	output alu_word_t red
);

	// Ten bit signed accumulation of the four bytes
	logic [9:0] red_sum;

	// Four independent nibble lanes
	for (genvar i = 0; i < 4; i++) begin : g_nibble
		// Operand nibbles of this lane
		logic [3:0] na;
		logic [3:0] nb;
		// One extra bit keeps the true signed sum
		logic [4:0] lane_sum;

		assign na = a[4*i +: 4];
		assign nb = b[4*i +: 4];

		// Sign extend both nibbles before adding
		assign lane_sum = {na[3], na} + {nb[3], nb};

		always_comb begin
			// Top two bits disagree on overflow
			if (lane_sum[4] != lane_sum[3]) begin
				// Clamp to +7 or -8, direction from the true sign
				paddsb[4*i +: 4] = lane_sum[4] ? 4'h8 : 4'h7;
			end else begin
				paddsb[4*i +: 4] = lane_sum[3:0];
			end
		end
	end

	// Bytes are signed, extend each to 10 bits
	assign red_sum = {{2{a[15]}}, a[15:8]} +
		{{2{a[7]}}, a[7:0]} +
		{{2{b[15]}}, b[15:8]} +
		{{2{b[7]}}, b[7:0]};

	// Result sign extended to a full word
	assign red = {{6{red_sum[9]}}, red_sum};

endmodule

/* hdl/alu_core.sv */
`timescale 1ns/100ps

module alu_core import alu_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  alu_req_t  req,
	input  logic      in_valid,
	output alu_word_t result,
	output logic      out_valid,
	output flags_t    flag_new,
	output flags_t    flag_we
);

	// Adder outputs
	alu_word_t sum;
	logic      ovfl;
	alu_word_t addr;

	// Other datapath results
	alu_word_t shifted;
	alu_word_t paddsb;
	alu_word_t red;

	// Selected result ahead of the output register
	alu_word_t alu_out;

	// Main adder, subtracts only for SUB
	add_sub16 i_add_sub (
		.a    (req.a),
		.b    (req.b),
		.sub  (req.op == SUB),
		.sum  (sum),
		.ovfl (ovfl)
	);

	// LW/SW address, base is halfword aligned
	// overflow is meaningless for an address
	add_sub16 i_addr_add (
		.a    ({req.a[15:1], 1'b0}),
		.b    (req.b),
		.sub  (1'b0),
		.sum  (addr),
		.ovfl ()
	);

	// Shift amount is the low nibble of b
	shift_rotate i_shift_rotate (
		.data    (req.a),
		.amount  (req.b[3:0]),
		.mode    (req.op),
		.shifted (shifted)
	);

	subword_arith i_subword_arith (
		.a      (req.a),
		.b      (req.b),
		.paddsb (paddsb),
		.red    (red)
	);

	// Result select
	always_comb begin
		case (req.op)
			ADD, SUB:      alu_out = sum;
			XOR:           alu_out = req.a ^ req.b;
			RED:           alu_out = red;
			SLL, SRA, ROR: alu_out = shifted;
			PADDSB:        alu_out = paddsb;
			LW, SW:        alu_out = addr;
			// Keep high byte of a, load low byte
			LLB:           alu_out = {req.a[15:8], req.b[7:0]};
			// Load high byte, keep low byte of a
			LHB:           alu_out = {req.b[7:0], req.a[7:0]};
			// Branch, PCS and halt pass a through
			default:       alu_out = req.a;
		endcase
	end

	// Candidate flag values, n and v always come from the main adder
	assign flag_new.n = sum[15];
	assign flag_new.z = (alu_out == '0);
	assign flag_new.v = ovfl;

	// Which flags this opcode updates
	always_comb begin
		flag_we = '0;
		case (req.op)
			ADD, SUB: begin
				flag_we.n = in_valid;
				flag_we.z = in_valid;
				flag_we.v = in_valid;
			end
			// Logic ops touch z only
			XOR, SLL, SRA, ROR: flag_we.z = in_valid;
			default: flag_we = '0;
		endcase
	end

	// One cycle latency, result holds between requests
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result    <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				result <= alu_out;
			end
		end
	end

endmodule

/* hdl/flag_reg.sv */
`timescale 1ns/100ps

module flag_reg import alu_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  flags_t flag_new,
	input  flags_t flag_we,
	output flags_t flags
);

	// Each flag is its own enabled register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else begin
			// Negative
			if (flag_we.n) begin
				flags.n <= flag_new.n;
			end
			// Zero
			if (flag_we.z) begin
				flags.z <= flag_new.z;
			end
			// Overflow
			if (flag_we.v) begin
				flags.v <= flag_new.v;
			end
		end
	end

endmodule

/* hdl/exec_stage.sv */
`timescale 1ns/100ps

module exec_stage import alu_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  alu_req_t  req,
	input  logic      in_valid,
	output alu_word_t result,
	output logic      out_valid,
	output flags_t    flags
);

	// Flag update request from the ALU
	flags_t flag_new;
	flags_t flag_we;

	// Registered ALU, updates land together with out_valid
	alu_core i_alu_core (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.in_valid  (in_valid),
		.result    (result),
		.out_valid (out_valid),
		.flag_new  (flag_new),
		.flag_we   (flag_we)
	);

	// Condition flags for branch logic
	flag_reg i_flag_reg (
		.clk      (clk),
		.arst_n   (arst_n),
		.flag_new (flag_new),
		.flag_we  (flag_we),
		.flags    (flags)
	);

endmodule

/* test/tb_exec_stage.sv */
`timescale 1ns/100ps

module tb_exec_stage import alu_pkg::*; ();

	// Expected response of one request
	typedef struct packed {
		alu_word_t   res;
		flags_t      flg;
		logic [31:0] due;
	} expect_t;

	logic      clk;
	logic      arst_n;
	alu_req_t  req;
	logic      in_valid;
	alu_word_t result;
	logic      out_valid;
	flags_t    flags;

	// Scoreboard state
	expect_t     exp_q[$];
	flags_t      model_flags;
	logic [31:0] cycle = '0;
	logic [31:0] rng_state;
	string       test_name;

	exec_stage i_exec_stage (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.in_valid  (in_valid),
		.result    (result),
		.out_valid (out_valid),
		.flags     (flags)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Rising edge count, used for the latency check
	always @(posedge clk) begin
		cycle <= cycle + 32'd1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Sign extension helpers for the model
	function automatic int sext4(input logic [3:0] x);
		return {{28{x[3]}}, x};
	endfunction

	function automatic int sext8(input logic [7:0] x);
		return {{24{x[7]}}, x};
	endfunction

	function automatic int sext16(input logic [15:0] x);
		return {{16{x[15]}}, x};
	endfunction

	// Reference model, result plus next flag state
	function automatic alu_word_t ref_alu(input alu_req_t r, input flags_t cur,
			output flags_t nxt);
		int          s;
		int          lane;
		alu_word_t   res;
		logic [31:0] rot;
		logic [3:0]  amt;
		nxt = cur;
		amt = r.b[3:0];
		case (r.op)
			ADD, SUB: begin
				// Exact signed sum, overflow when outside 16-bit range
				if (r.op == ADD) begin
					s = sext16(r.a) + sext16(r.b);
				end else begin
					s = sext16(r.a) - sext16(r.b);
				end
				res = s[15:0];
				nxt.n = res[15];
				nxt.z = (res == 16'h0000);
				nxt.v = (s > 32767) || (s < -32768);
			end
			XOR: res = r.a ^ r.b;
			SLL: res = r.a << amt;
			SRA: res = $signed(r.a) >>> amt;
			ROR: begin
				rot = {r.a, r.a} >> amt;
				res = rot[15:0];
			end
			PADDSB: begin
				for (int i = 0; i < 4; i++) begin
					lane = sext4(r.a[4*i +: 4]) + sext4(r.b[4*i +: 4]);
					// Clamp each nibble to -8..7
					if (lane > 7) begin
						lane = 7;
					end
					if (lane < -8) begin
						lane = -8;
					end
					res[4*i +: 4] = lane[3:0];
				end
			end
			RED: begin
				s = sext8(r.a[15:8]) + sext8(r.a[7:0]) + sext8(r.b[15:8]) + sext8(r.b[7:0]);
				res = s[15:0];
			end
			LW, SW: res = (r.a & 16'hFFFE) + r.b;
			LLB: res = {r.a[15:8], r.b[7:0]};
			LHB: res = {r.b[7:0], r.a[7:0]};
			// Control flow codes pass a through
			default: res = r.a;
		endcase
		// Logic and shift ops only touch z
		if (r.op inside {XOR, SLL, SRA, ROR}) begin
			nxt.z = (res == 16'h0000);
		end
		return res;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_result(input string name, input alu_word_t want, input alu_word_t got);
		if (got !== want) begin
			abort_run($sformatf("MISMATCH %s result expected %h actual %h", name, want, got));
		end
	endtask

	task automatic check_flags(input string name, input flags_t want, input flags_t got);
		if (got !== want) begin
			abort_run($sformatf("MISMATCH %s flags(nzv) expected %b actual %b", name, want, got));
		end
	endtask

	task automatic check_valid(input string name, input logic want, input logic got);
		if (got !== want) begin
			abort_run($sformatf("MISMATCH %s out_valid expected %b actual %b", name, want, got));
		end
	endtask

	// Compare process, outputs are settled by the falling edge
	always @(negedge clk) begin : compare
		expect_t e;
		if (arst_n && out_valid) begin
			if (exp_q.size() == 0) begin
				abort_run("out_valid was high with no request outstanding");
			end else begin
				e = exp_q.pop_front();
				if (e.due != cycle) begin
					abort_run($sformatf("%s: result came at cycle %0d, one cycle latency means %0d",
						test_name, cycle, e.due));
				end else begin
					check_result(test_name, e.res, result);
					check_flags(test_name, e.flg, flags);
				end
			end
		end
	end

	// One request, expected values queued for the compare process
	task automatic issue(input alu_op_e op, input alu_word_t a, input alu_word_t b);
		alu_req_t  r;
		alu_word_t want;
		flags_t    nxt;
		r = {op, a, b};
		want = ref_alu(r, model_flags, nxt);
		model_flags = nxt;
		@(posedge clk);
		#10;
		req = r;
		in_valid = 1'b1;
		exp_q.push_back('{res: want, flg: nxt, due: cycle + 32'd1});
	endtask

	// Gap cycle, req may carry junk that must be ignored
	task automatic idle_cycle(input alu_req_t junk);
		@(posedge clk);
		#10;
		req = junk;
		in_valid = 1'b0;
	endtask

	task automatic wait_drain(input int limit);
		int n;
		idle_cycle(req);
		n = 0;
		while (exp_q.size() != 0 && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			abort_run($sformatf("%s: %0d results never came back", test_name, exp_q.size()));
		end
	endtask

	task automatic check_cleared();
		check_valid(test_name, 1'b0, out_valid);
		check_result(test_name, 16'h0000, result);
		check_flags(test_name, 3'b000, flags);
	endtask

	task automatic run_reset();
		test_name = "reset";
		repeat (16) @(posedge clk);
		#10;
		check_cleared();
		arst_n = 1'b1;
		@(posedge clk);
		#10;
		check_cleared();
	endtask

	// Reset in the middle of a cycle, with result and flags nonzero
	task automatic run_async_reset();
		test_name = "async_reset";
		// Result 7FFF with v set
		issue(SUB, 16'h8000, 16'h0001);
		wait_drain(20);
		#10;
		arst_n = 1'b0;
		#10;
		// Clear lands before the next clock edge
		check_cleared();
		model_flags = '0;
		repeat (16) @(posedge clk);
		#10;
		arst_n = 1'b1;
		@(posedge clk);
		#10;
		check_cleared();
	endtask

	task automatic run_add_sub();
		test_name = "add_sub";
		issue(ADD, 16'h7FFF, 16'h0001);
		// Lone request, extra pulses would hit an empty queue
		idle_cycle('0);
		idle_cycle('0);
		idle_cycle('0);
		issue(SUB, 16'h8000, 16'h0001);
		issue(SUB, 16'h1234, 16'h1234);
		issue(ADD, 16'hFFFF, 16'h0001);
		issue(ADD, 16'h8000, 16'h8000);
		issue(SUB, 16'h0000, 16'h8000);
		issue(SUB, 16'h0003, 16'h0005);
		issue(ADD, 16'h1234, 16'h4321);
		wait_drain(20);
	endtask

	task automatic run_shifts();
		test_name = "shift";
		// n and v set, so a stray write shows
		issue(ADD, 16'h7FFF, 16'h0001);
		for (int amt = 0; amt < 16; amt++) begin
			// Upper bits of b are junk, only b[3:0] counts
			issue(SLL, 16'hB4C3, {12'hA5C, amt[3:0]});
			issue(SRA, 16'hB4C3, {12'h3C1, amt[3:0]});
			issue(ROR, 16'hB4C3, {12'hFFF, amt[3:0]});
			issue(SLL, 16'h8000, {12'h000, amt[3:0]});
			issue(SRA, 16'h7FFF, {12'h800, amt[3:0]});
			issue(ROR, 16'h0001, {12'h5A5, amt[3:0]});
		end
		issue(XOR, 16'h5A5A, 16'h5A5A);
		issue(XOR, 16'hF0F0, 16'h0FF0);
		wait_drain(20);
	endtask

	task automatic run_subword();
		test_name = "subword";
		// Leaves v set and z clear
		issue(SUB, 16'h8000, 16'h0001);
		issue(PADDSB, 16'h7777, 16'h1111);
		issue(PADDSB, 16'h8888, 16'hFFFF);
		issue(PADDSB, 16'h7F81, 16'h2C9E);
		issue(RED, 16'h7F80, 16'h01FF);
		issue(RED, 16'h7F7F, 16'h7F7F);
		issue(RED, 16'h8080, 16'h8080);
		issue(LLB, 16'hABCD, 16'h1234);
		issue(LHB, 16'hABCD, 16'h1234);
		issue(LW, 16'h1001, 16'h0010);
		issue(SW, 16'hFFFF, 16'h0003);
		// Zero address, z must still hold
		issue(LW, 16'h0001, 16'h0000);
		wait_drain(20);
	endtask

	task automatic run_random(input int count);
		logic [31:0] r1;
		logic [31:0] r2;
		alu_word_t   b;
		test_name = "random";
		for (int k = 0; k < count; k++) begin
			r1 = next_rand();
			r2 = next_rand();
			// About one gap in four
			if (r2[9:8] == 2'b00) begin
				idle_cycle({r2[3:0], r1});
			end
			// Equal operands now and then for zero results
			b = (r2[2:0] == 3'b000) ? r1[15:0] : r1[31:16];
			issue(alu_op_e'(r2[7:4]), r1[15:0], b);
		end
		wait_drain(20);
	endtask

	initial begin
		arst_n = 1'b0;
		in_valid = 1'b0;
		req = '0;
		model_flags = '0;
		rng_state = 32'd60185;
		test_name = "init";
		run_reset();
		run_add_sub();
		run_shifts();
		run_subword();
		run_async_reset();
		run_random(300);
		$display("test passed");
		$finish;
	end

endmodule

/* tb.f */
hdl/alu_pkg.sv
hdl/add_sub16.sv
hdl/shift_rotate.sv
hdl/subword_arith.sv
hdl/alu_core.sv
hdl/flag_reg.sv
hdl/exec_stage.sv
test/tb_exec_stage.sv

/* Makefile */
TOP = tb_exec_stage

.PHONY: all run lint clean

all: run

# Build with Verilator, run, and pass only if the pass line shows up
run:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -Mdir obj_dir -f tb.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^test passed$$"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir
